/* rtl/fir_pkg.sv */
`default_nettype none

package fir_pkg;

   // Sample and coefficient formats
   localparam int sample_w = 18;
   localparam int coef_w = 16;

   // 15 taps folded into 7 symmetric pairs plus the center tap
   localparam int num_taps = 15;
   localparam int num_coefs = 8;
   localparam int coef_addr_w = 3;

   // Datapath widths
   localparam int prod_w = 2 * sample_w;
   localparam int acc_w = 43;
   localparam int out_lsb = 16;

   // Strobes needed before the output pipeline holds valid data
   localparam int pipe_depth = 4;

   // Symmetric saturation limits
   localparam logic [sample_w-1:0] sat_pos = 18'h1ffff;
   localparam logic [sample_w-1:0] sat_neg = 18'h20001;

   typedef enum logic [0:0] {
      op_write = 1'b0,
      op_apply = 1'b1
   } coef_op_t;

   typedef enum logic [1:0] {
      idle,
      busy,
      wait_release
   } coef_state_t;

endpackage

`default_nettype wire

/* rtl/mpy18x18_ce.sv */
`default_nettype none

// Maps onto one DSP block of the target library
module mpy18x18_ce (
   input  logic                                clk,
   input  logic                                ce,
   input  logic signed [fir_pkg::sample_w-1:0] a,
   input  logic signed [fir_pkg::sample_w-1:0] b,
   output logic signed [fir_pkg::prod_w-1:0]   p
);

   logic signed [fir_pkg::prod_w-1:0] prod;

   assign prod = a * b;

   // Single pipeline stage, held between strobes
   always_ff @(posedge clk) begin
      if (ce) begin
         p <= prod;
      end
   end

endmodule

`default_nettype wire

/* rtl/symmetric_fir.sv */
`default_nettype none

module symmetric_fir (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             sync_in,
   input  logic [fir_pkg::coef_w-1:0]       c0c14,
   input  logic [fir_pkg::coef_w-1:0]       c1c13,
   input  logic [fir_pkg::coef_w-1:0]       c2c12,
   input  logic [fir_pkg::coef_w-1:0]       c3c11,
   input  logic [fir_pkg::coef_w-1:0]       c4c10,
   input  logic [fir_pkg::coef_w-1:0]       c5c9,
   input  logic [fir_pkg::coef_w-1:0]       c6c8,
   input  logic [fir_pkg::coef_w-1:0]       c7,
   input  logic [fir_pkg::sample_w-1:0]     in,
   output logic [fir_pkg::sample_w-1:0]     out
);

   localparam int sw = fir_pkg::sample_w;
   localparam int nc = fir_pkg::num_coefs;
   localparam int nt = fir_pkg::num_taps;
   localparam int pw = fir_pkg::prod_w;
   localparam int aw = fir_pkg::acc_w;
   localparam int out_msb = fir_pkg::out_lsb + sw - 1;

   logic [sw-1:0]                 dly [1:nt-1];
   logic [fir_pkg::coef_w-1:0]    coef [nc];
   logic [sw:0]                   pair_sum [nc-1];
   logic signed [sw-1:0]          mult_a [nc];
   logic signed [sw-1:0]          mult_b [nc];
   logic signed [pw-1:0]          prod [nc];
   logic signed [aw-1:0]          acc_sum;
   logic signed [aw-1:0]          acc_r;
   logic [sw-1:0]                 data_bits;
   logic                          sat_pos_r;
   logic                          sat_neg_r;

   assign coef[0] = c0c14;
   assign coef[1] = c1c13;
   assign coef[2] = c2c12;
   assign coef[3] = c3c11;
   assign coef[4] = c4c10;
   assign coef[5] = c5c9;
   assign coef[6] = c6c8;
   assign coef[7] = c7;

   // Delay line, dly[k] holds the sample from k strobes ago
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int k = 1; k < nt; k++) begin
            dly[k] <= '0;
         end
      end else if (sync_in) begin
         dly[1] <= in;
         for (int k = 2; k < nt; k++) begin
            dly[k] <= dly[k-1];
         end
      end
   end

   // Pre-adders, the current input pairs with the oldest sample
   always_comb begin
      pair_sum[0] = {in[sw-1], in} + {dly[nt-1][sw-1], dly[nt-1]};
      for (int k = 1; k < nc - 1; k++) begin
         pair_sum[k] = {dly[k][sw-1], dly[k]} + {dly[nt-1-k][sw-1], dly[nt-1-k]};
      end
   end

   always_comb begin
      for (int k = 0; k < nc - 1; k++) begin
         // Upper bits keep the halved sum
         mult_a[k] = pair_sum[k][sw:1];
      end
      mult_a[nc-1] = {dly[nc-1][sw-1], dly[nc-1][sw-1:1]};
      for (int k = 0; k < nc; k++) begin
         mult_b[k] = {coef[k], {(sw - fir_pkg::coef_w){1'b0}}};
      end
   end

   for (genvar g = 0; g < nc; g++) begin : g_tap
      mpy18x18_ce u_mpy (
         .clk (clk),
         .ce  (sync_in),
         .a   (mult_a[g]),
         .b   (mult_b[g]),
         .p   (prod[g])
      );
   end

   always_comb begin
      acc_sum = '0;
      for (int k = 0; k < nc; k++) begin
         acc_sum = acc_sum + {{(aw - pw){prod[k][pw-1]}}, prod[k]};
      end
   end

   // Sum, slice with overflow detect, then saturated output
   always_ff @(posedge clk) begin
      if (sync_in) begin
         acc_r     <= acc_sum;
         data_bits <= acc_r[out_msb:fir_pkg::out_lsb];
         sat_pos_r <= !acc_r[aw-1] && (acc_r[aw-1:out_msb] != '0);
         sat_neg_r <= acc_r[aw-1] && (acc_r[aw-1:out_msb] != '1);
         if (sat_pos_r) begin
            out <= fir_pkg::sat_pos;
         end else if (sat_neg_r) begin
            out <= fir_pkg::sat_neg;
         end else begin
            out <= data_bits;
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/coef_bank.sv */
`default_nettype none

module coef_bank (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              sync_in,
   input  logic                              coef_req,
   input  fir_pkg::coef_op_t                 coef_op,
   input  logic [fir_pkg::coef_addr_w-1:0]   coef_addr,
   input  logic [fir_pkg::coef_w-1:0]        coef_data,
   output logic                              coef_ack,
   output logic [fir_pkg::coef_w-1:0]        c0c14,
   output logic [fir_pkg::coef_w-1:0]        c1c13,
   output logic [fir_pkg::coef_w-1:0]        c2c12,
   output logic [fir_pkg::coef_w-1:0]        c3c11,
   output logic [fir_pkg::coef_w-1:0]        c4c10,
   output logic [fir_pkg::coef_w-1:0]        c5c9,
   output logic [fir_pkg::coef_w-1:0]        c6c8,
   output logic [fir_pkg::coef_w-1:0]        c7
);

   logic [fir_pkg::coef_w-1:0] shadow [fir_pkg::num_coefs];
   logic [fir_pkg::coef_w-1:0] active [fir_pkg::num_coefs];
   fir_pkg::coef_state_t       state;

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= fir_pkg::idle;
         coef_ack <= 1'b0;
         for (int k = 0; k < fir_pkg::num_coefs; k++) begin
            shadow[k] <= '0;
            active[k] <= '0;
         end
      end else begin
         case (state)
            fir_pkg::idle: begin
               if (coef_req) begin
                  if (coef_op == fir_pkg::op_write) begin
                     shadow[coef_addr] <= coef_data;
                  end
                  state <= fir_pkg::busy;
               end
            end
            fir_pkg::busy: begin
               // Apply is held off until a cycle without a strobe
               if (coef_op == fir_pkg::op_write || !sync_in) begin
                  if (coef_op == fir_pkg::op_apply) begin
                     active <= shadow;
                  end
                  coef_ack <= 1'b1;
                  state    <= fir_pkg::wait_release;
               end
            end
            fir_pkg::wait_release: begin
               if (!coef_req) begin
                  coef_ack <= 1'b0;
                  state    <= fir_pkg::idle;
               end
            end
            default: state <= fir_pkg::idle;
         endcase
      end
   end

   assign c0c14 = active[0];
   assign c1c13 = active[1];
   assign c2c12 = active[2];
   assign c3c11 = active[3];
   assign c4c10 = active[4];
   assign c5c9  = active[5];
   assign c6c8  = active[6];
   assign c7    = active[7];

endmodule

`default_nettype wire

/* rtl/fir_iq_top.sv */
`default_nettype none

module fir_iq_top (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              sync_in,
   input  logic                              coef_req,
   input  fir_pkg::coef_op_t                 coef_op,
   input  logic [fir_pkg::coef_addr_w-1:0]   coef_addr,
   input  logic [fir_pkg::coef_w-1:0]        coef_data,
   output logic                              coef_ack,
   input  logic [fir_pkg::sample_w-1:0]      in_i,
   input  logic [fir_pkg::sample_w-1:0]      in_q,
   output logic [fir_pkg::sample_w-1:0]      out_i,
   output logic [fir_pkg::sample_w-1:0]      out_q,
   output logic                              out_valid
);

   localparam int cnt_w = $clog2(fir_pkg::pipe_depth + 1);

   logic [fir_pkg::coef_w-1:0] c0c14, c1c13, c2c12, c3c11;
   logic [fir_pkg::coef_w-1:0] c4c10, c5c9, c6c8, c7;
   logic [cnt_w-1:0]           strobe_cnt;

   coef_bank u_coef_bank (
      .clk       (clk),
      .reset     (reset),
      .sync_in   (sync_in),
      .coef_req  (coef_req),
      .coef_op   (coef_op),
      .coef_addr (coef_addr),
      .coef_data (coef_data),
      .coef_ack  (coef_ack),
      .c0c14     (c0c14),
      .c1c13     (c1c13),
      .c2c12     (c2c12),
      .c3c11     (c3c11),
      .c4c10     (c4c10),
      .c5c9      (c5c9),
      .c6c8      (c6c8),
      .c7        (c7)
   );

   symmetric_fir fir_i (
      .clk (clk), .reset (reset), .sync_in (sync_in),
      .c0c14 (c0c14), .c1c13 (c1c13), .c2c12 (c2c12), .c3c11 (c3c11),
      .c4c10 (c4c10), .c5c9 (c5c9), .c6c8 (c6c8), .c7 (c7),
      .in (in_i), .out (out_i)
   );

   symmetric_fir fir_q (
      .clk (clk), .reset (reset), .sync_in (sync_in),
      .c0c14 (c0c14), .c1c13 (c1c13), .c2c12 (c2c12), .c3c11 (c3c11),
      .c4c10 (c4c10), .c5c9 (c5c9), .c6c8 (c6c8), .c7 (c7),
      .in (in_q), .out (out_q)
   );

   // Output is trusted once the pipeline has been refilled since reset
   always_ff @(posedge clk) begin
      if (reset) begin
         strobe_cnt <= '0;
         out_valid  <= 1'b0;
      end else begin
         if (sync_in && strobe_cnt != cnt_w'(fir_pkg::pipe_depth)) begin
            strobe_cnt <= strobe_cnt + 1'b1;
         end
         out_valid <= sync_in && (strobe_cnt >= cnt_w'(fir_pkg::pipe_depth - 1));
      end
   end

endmodule

`default_nettype wire

/* test/fir_iq_tb.sv */
`default_nettype none

module fir_iq_tb;

   localparam int sw = fir_pkg::sample_w;
   localparam int cw = fir_pkg::coef_w;
   localparam int nt = fir_pkg::num_taps;
   localparam int nc = fir_pkg::num_coefs;

   logic                            clk = 1'b0;
   logic                            reset;
   logic                            sync_in;
   logic                            coef_req;
   logic                            coef_ack;
   fir_pkg::coef_op_t               coef_op;
   logic [fir_pkg::coef_addr_w-1:0] coef_addr;
   logic [cw-1:0]                   coef_data;
   logic [sw-1:0]                   in_i;
   logic [sw-1:0]                   in_q;
   logic [sw-1:0]                   out_i;
   logic [sw-1:0]                   out_q;
   logic                            out_valid;

   // Reference state, taps[0] is the newest sample
   logic signed [sw-1:0]            taps_i [nt];
   logic signed [sw-1:0]            taps_q [nt];
   logic [cw-1:0]                   shadow_m [nc];
   logic [cw-1:0]                   active_m [nc];
   logic [sw-1:0]                   exp_i [$];
   logic [sw-1:0]                   exp_q [$];

   // Parsed data file
   logic [7:0]                      kinds [$];
   logic [31:0]                     f1 [$];
   logic [31:0]                     f2 [$];
   logic [31:0]                     f3 [$];
   string                           names [$];

   int    limit_cycles = 0;
   int    test_errors = 0;
   int    tests_passed = 0;
   int    tests_failed = 0;
   string test_name = "";

   fir_iq_top fir_iq_top_i (.*);

   always #4 clk = ~clk;

   // Folded 15-tap sum, bits 33:16 of it, limited to the 18-bit range
   function automatic logic [sw-1:0] fir_output(input logic signed [sw-1:0] taps [nt]);
      longint acc;
      longint pair;
      longint y;
      acc = 0;
      for (int k = 0; k < nc; k++) begin
         if (k == nc - 1) begin
            pair = longint'(taps[k]) >>> 1;
         end else begin
            pair = (longint'(taps[k]) + longint'(taps[nt-1-k])) >>> 1;
         end
         acc += pair * (longint'($signed(active_m[k])) * 4);
      end
      y = acc >>> 16;
      if (y > 131071) begin
         return fir_pkg::sat_pos;
      end
      if (y < -131072) begin
         return fir_pkg::sat_neg;
      end
      return y[sw-1:0];
   endfunction

   task automatic report_problem(input string what);
      $display("ERROR at %0t: %s", $time, what);
      test_errors++;
   endtask

   task automatic check_value(input string name, input logic [sw-1:0] expected,
                              input logic [sw-1:0] actual);
      assert (actual === expected) else begin
         $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
         test_errors++;
      end
   endtask

   // Four-phase req/ack, inputs held while req is high
   task automatic run_command(input fir_pkg::coef_op_t op, input logic [31:0] addr,
                              input logic [31:0] data);
      int n;
      assert (!coef_ack) else report_problem("coef_ack high before coef_req was raised");
      coef_op = op;
      coef_addr = addr[fir_pkg::coef_addr_w-1:0];
      coef_data = data[cw-1:0];
      coef_req = 1'b1;
      n = 0;
      while (!coef_ack && n < 10) begin
         @(negedge clk);
         n++;
      end
      assert (coef_ack) else report_problem("no coef_ack within 10 cycles of coef_req");
      @(negedge clk);
      assert (coef_ack) else report_problem("coef_ack fell while coef_req was still high");
      coef_req = 1'b0;
      n = 0;
      while (coef_ack && n < 10) begin
         @(negedge clk);
         n++;
      end
      assert (!coef_ack) else report_problem("coef_ack still high 10 cycles after coef_req fell");
   endtask

   task automatic strobe(input logic [sw-1:0] si, input logic [sw-1:0] sq);
      for (int k = nt - 1; k > 0; k--) begin
         taps_i[k] = taps_i[k-1];
         taps_q[k] = taps_q[k-1];
      end
      taps_i[0] = si;
      taps_q[0] = sq;
      exp_i.push_back(fir_output(taps_i));
      exp_q.push_back(fir_output(taps_q));
      in_i = si;
      in_q = sq;
      sync_in = 1'b1;
      @(negedge clk);
      sync_in = 1'b0;
   endtask

   // Starts on an idle cycle so that no output check is pending
   task automatic apply_reset;
      @(negedge clk);
      reset = 1'b1;
      exp_i.delete();
      exp_q.delete();
      for (int k = 0; k < nt; k++) begin
         taps_i[k] = '0;
         taps_q[k] = '0;
      end
      for (int k = 0; k < nc; k++) begin
         shadow_m[k] = '0;
         active_m[k] = '0;
      end
      repeat (3) @(negedge clk);
      reset = 1'b0;
   endtask

   task automatic finish_test;
      @(negedge clk);
      // At most three results can still be in the output pipeline
      assert (exp_i.size() < 4) else report_problem("fewer out_valid pulses than strobes");
      if (test_name != "" || test_errors != 0) begin
         if (test_errors == 0) begin
            tests_passed++;
            $display("test %0s: ok", test_name);
         end else begin
            tests_failed++;
            $display("test %0s: %0d errors", test_name, test_errors);
         end
      end
      test_errors = 0;
   endtask

   // An out_valid pulse carries the result of the strobe three before the latest
   always @(negedge clk) begin
      if (out_valid) begin
         assert (exp_i.size() >= 4) else report_problem("out_valid high before four strobes");
         if (exp_i.size() >= 4) begin
            check_value("out_i", exp_i.pop_front(), out_i);
            check_value("out_q", exp_q.pop_front(), out_q);
         end
      end
   end

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("Run stopped by the watchdog after %0d cycles", limit_cycles);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      int fd;
      int rc;
      int samples;
      int commands;
      logic [8*128-1:0] line;
      logic [8*32-1:0] word;
      logic [8*32-1:0] name_buf;
      logic [31:0] v1;
      logic [31:0] v2;
      logic [31:0] v3;
      void'($urandom(32'hd8f4_1c41));
      reset = 1'b1;
      sync_in = 1'b0;
      coef_req = 1'b0;
      coef_op = fir_pkg::op_write;
      coef_addr = '0;
      coef_data = '0;
      in_i = '0;
      in_q = '0;
      samples = 0;
      commands = 0;
      fd = $fopen("test/fir_testdata.txt", "r");
      if (fd == 0) begin
         $display("Cannot open test/fir_testdata.txt");
         tests_failed++;
      end else begin
         while (!$feof(fd)) begin
            line = '0;
            word = '0;
            name_buf = '0;
            v1 = 0;
            v2 = 0;
            v3 = 0;
            rc = $fgets(line, fd);
            rc = $sscanf(line, "%s", word);
            if (rc >= 1 && word[7:0] != "#") begin
               if (word[7:0] == "t") begin
                  rc = $sscanf(line, "%s %s", word, name_buf);
               end else if (word[7:0] == "n") begin
                  rc = $sscanf(line, "%s %d", word, v3);
               end else begin
                  rc = $sscanf(line, "%s %h %h %d", word, v1, v2, v3);
               end
               if (word[7:0] inside {"s", "g", "n"}) begin
                  samples += v3;
               end
               if (word[7:0] inside {"c", "a", "r"}) begin
                  commands++;
               end
               kinds.push_back(word[7:0]);
               f1.push_back(v1);
               f2.push_back(v2);
               f3.push_back(v3);
               names.push_back($sformatf("%0s", name_buf));
            end
         end
         $fclose(fd);
      end
      limit_cycles = 40 * samples + 20 * commands + 50;
      apply_reset();
      for (int j = 0; j < kinds.size(); j++) begin
         case (kinds[j])
            "t": begin
               finish_test();
               test_name = names[j];
            end
            "c": begin
               run_command(fir_pkg::op_write, f1[j], f2[j]);
               shadow_m[f1[j][fir_pkg::coef_addr_w-1:0]] = f2[j][cw-1:0];
            end
            "a": begin
               run_command(fir_pkg::op_apply, 0, 0);
               active_m = shadow_m;
            end
            "s", "g": begin
               repeat (f3[j]) begin
                  if (kinds[j] == "g") begin
                     repeat ($urandom_range(3, 0)) @(negedge clk);
                  end
                  strobe(f1[j][sw-1:0], f2[j][sw-1:0]);
               end
            end
            "n": begin
               repeat (f3[j]) begin
                  repeat ($urandom_range(3, 0)) @(negedge clk);
                  strobe(sw'($urandom()), sw'($urandom()));
               end
            end
            "e": begin
               check_value("out_i", f1[j][sw-1:0], out_i);
               check_value("out_q", f2[j][sw-1:0], out_q);
            end
            "r": apply_reset();
            default: report_problem("unknown line kind in test/fir_testdata.txt");
         endcase
      end
      finish_test();
      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* test/fir_testdata.txt */
# Columns: kind, then fields in hex; the count at the end of s, g and n is decimal
# t name | c addr value | a | s in_i in_q count | g (s with idle gaps) | n count | e out_i out_q | r
t handshake
c 0 0100
c 1 0200
c 2 0300
c 3 0400
c 4 0500
c 5 0600
c 6 0700
c 7 1000
a
t impulse
s 10000 00000 1
s 00000 00000 17
t random_gaps
c 3 f123
c 6 8000
a
n 60
g 1fff0 0000f 6
t shadow_bank
c 2 7000
c 5 9100
s 0abcd 3fff0 20
a
s 12345 20000 20
t saturation
c 6 7fff
c 7 7fff
a
s 1ffff 20000 18
e 1ffff 20001
t mid_reset
s 05555 3aaaa 5
r
s 01000 3f000 6
c 7 2000
a
s 01000 3f000 20

/* vlog.f */
rtl/fir_pkg.sv
rtl/mpy18x18_ce.sv
rtl/symmetric_fir.sv
rtl/coef_bank.sv
rtl/fir_iq_top.sv
test/fir_iq_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the FIR testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f vlog.f --top-module fir_iq_tb -o fir_iq_sim

out=$(./obj_dir/fir_iq_sim)
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
   exit 0
fi
exit 1
